/* vlog.f */
src/invaders_pkg.sv
src/frame_timer.sv
src/game_control.sv
src/player_ship.sv
src/alien_row.sv
src/player_bullet.sv
src/plot_engine.sv
src/invaders_top.sv
sim/invaders_chk.sv
sim/invaders_tb.sv

/* sim/invaders_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for invaders_top: button phases drive the
// game, the bound checker's assertions judge the stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module invaders_tb;

  localparam int     FRAME_DIV = 25000;
  localparam int     N_FRAMES  = 180;   // Upper bound over all phases
  localparam longint LIMIT_NS  = longint'(N_FRAMES) * FRAME_DIV * 10 + 1_000_000;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 go;
  logic                 btn_left;
  logic                 btn_right;
  logic                 btn_fire;
  invaders_pkg::pixel_t pix;
  logic                 pix_valid;
  logic                 in_game;

  logic [31:0] lfsr = 32'hb946a27a;
  int          mismatches = 0;
  int          phases = 0;
  int          errs_seen = 0;
  logic        top_seen = 1'b0;   // Bullet reached row 0

  invaders_top #(
    .FRAME_DIV (FRAME_DIV),
    .PLAYER_DIV(1),
    .ALIEN_DIV (2),
    .BULLET_DIV(1)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .go       (go),
    .btn_left (btn_left),
    .btn_right(btn_right),
    .btn_fire (btn_fire),
    .pix      (pix),
    .pix_valid(pix_valid),
    .in_game  (in_game)
  );

  always #5 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic int take_bits(input int n);
    int   val;
    logic fb;
    val = 0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = (val << 1) | int'(fb);
    end
    return val;
  endfunction

  function automatic logic frame_origin();
    return pix_valid && pix.colour == invaders_pkg::COL_BLACK && pix.x == 0 && pix.y == 0;
  endfunction

  function automatic int total_errors();
    return dut0.chk0.fail_count + mismatches;
  endfunction

  always @(negedge clk) begin
    if (pix_valid && pix.colour == invaders_pkg::COL_BULLET && pix.y == 0) top_seen <= 1'b1;
  end

  task automatic expect_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH %0t: %s is %b, expected %b", $time, what, got, exp);
      mismatches++;
    end
  endtask

  // Counts clear origins, sampled mid-cycle
  task automatic wait_frames(input int n);
    repeat (n) begin
      @(negedge clk);
      while (!frame_origin()) @(negedge clk);
    end
  endtask

  // Hold fire until the bullet shows up
  task automatic press_fire();
    @(posedge clk);
    #1 btn_fire = 1'b1;
    @(negedge clk);
    while (!(pix_valid && pix.colour == invaders_pkg::COL_BULLET)) @(negedge clk);
    @(posedge clk);
    #1 btn_fire = 1'b0;
  endtask

  task automatic finish_phase(input string name);
    int fresh;
    fresh     = total_errors() - errs_seen;
    errs_seen = total_errors();
    phases++;
    $display("%0t phase %-7s %s (%0d errors)", $time, name, (fresh == 0) ? "ok" : "FAILED",
             fresh);
  endtask

  initial begin
    rst       = 1'b1;
    go        = 1'b0;
    btn_left  = 1'b0;
    btn_right = 1'b0;
    btn_fire  = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    repeat (40 + take_bits(6)) begin
      @(negedge clk);
      expect_bit(in_game, 1'b0, "in_game");
      expect_bit(pix_valid, 1'b0, "pix_valid");
    end
    finish_phase("idle");
    @(posedge clk);
    #1 go = 1'b1;
    @(posedge clk);
    #1 go = 1'b0;
    @(negedge clk);
    expect_bit(in_game, 1'b1, "in_game after go");
    wait_frames(1);
    finish_phase("go");
    @(posedge clk);
    #1 btn_right = 1'b1;
    wait_frames(20);
    @(posedge clk);
    #1 btn_right = 1'b0;
    finish_phase("right");
    btn_left = 1'b1;
    wait_frames(20);
    @(posedge clk);
    #1 btn_left = 1'b0;
    finish_phase("left");
    wait_frames(1 + take_bits(2));
    press_fire();
    finish_phase("fire");
    @(negedge clk);
    while (!top_seen) @(negedge clk);
    wait_frames(2);           // Retired bullet must stay dark
    finish_phase("climb");
    press_fire();
    wait_frames(2);
    finish_phase("refire");
    $display("%0d phases, %0d assertion failures, %0d mismatches", phases,
             dut0.chk0.fail_count, mismatches);
    if (total_errors() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(LIMIT_NS);
    $display("timeout: the run did not finish within %0d frames", N_FRAMES);
    $display("test failed");
    $finish;
  end

endmodule

/* sim/invaders_chk.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel stream checker, bound into invaders_top;
// shadows last frame's sprites for the assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module invaders_chk #(
  parameter int N_ALIENS = 3
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 go,
  input logic                 btn_left,
  input logic                 btn_right,
  input logic                 btn_fire,
  input logic                 in_game,
  input logic                 pix_valid,
  input invaders_pkg::pixel_t pix
);

  int fail_count = 0;

  logic                   blk;
  logic                   grn;
  logic                   red;
  logic                   wht;
  logic                   prev_valid;
  invaders_pkg::pixel_t   prev_pix;
  logic                   prev_blk;
  logic                   prev_grn;
  invaders_pkg::colour_t  last_col;    // Colour of the last valid pixel
  invaders_pkg::coord_x_t px_cur;      // Player x in the newest frame
  invaders_pkg::coord_x_t px_prev;
  invaders_pkg::coord_x_t bx_prev;
  invaders_pkg::coord_y_t by_prev;
  logic                   wht_this;
  logic                   wht_last;    // Previous frame drew a bullet
  logic                   armed;       // Fire seen since the last launch
  logic [6:0]             red_cnt;
  logic [2:0]             idx;
  int                     lane_lo;
  invaders_pkg::coord_x_t ax_prev [8];
  invaders_pkg::coord_y_t ay_prev [8];

  // Layer order inside a frame, sprites never draw black
  function automatic logic legal_next(input invaders_pkg::colour_t prev,
                                      input invaders_pkg::colour_t cur);
    case (prev)
      invaders_pkg::COL_BLACK:  return cur == invaders_pkg::COL_PLAYER;
      invaders_pkg::COL_PLAYER: return cur == invaders_pkg::COL_ALIEN;
      invaders_pkg::COL_ALIEN:  return cur inside {invaders_pkg::COL_BULLET,
                                                    invaders_pkg::COL_BLACK};
      default:                  return cur == invaders_pkg::COL_BLACK;
    endcase
  endfunction

  assign blk      = pix_valid && (pix.colour == invaders_pkg::COL_BLACK);
  assign grn      = pix_valid && (pix.colour == invaders_pkg::COL_PLAYER);
  assign red      = pix_valid && (pix.colour == invaders_pkg::COL_ALIEN);
  assign wht      = pix_valid && (pix.colour == invaders_pkg::COL_BULLET);
  assign prev_blk = prev_valid && (prev_pix.colour == invaders_pkg::COL_BLACK);
  assign prev_grn = prev_valid && (prev_pix.colour == invaders_pkg::COL_PLAYER);
  assign idx      = red_cnt[6:4];   // 16 pixels per alien box
  assign lane_lo  = int'(invaders_pkg::ALIEN_X0) + int'(idx) * invaders_pkg::LANE_W;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      prev_valid <= 1'b0;
      prev_pix   <= '0;
      last_col   <= invaders_pkg::COL_BULLET;   // As if a frame had just ended
      px_cur     <= invaders_pkg::PLAYER_X0;
      px_prev    <= invaders_pkg::PLAYER_X0;
      bx_prev    <= '0;
      by_prev    <= '0;
      wht_this   <= 1'b0;
      wht_last   <= 1'b0;
      armed      <= 1'b0;
      red_cnt    <= '0;
      for (int i = 0; i < 8; i++) begin
        ax_prev[i] <= invaders_pkg::coord_x_t'(int'(invaders_pkg::ALIEN_X0)
                                              + i * invaders_pkg::LANE_W);
        ay_prev[i] <= invaders_pkg::ALIEN_Y0;
      end
    end else begin
      prev_valid <= pix_valid;
      prev_pix   <= pix;
      if (pix_valid) last_col <= pix.colour;
      if (grn && !prev_grn) begin
        px_prev <= px_cur;
        px_cur  <= pix.x;
      end
      if (blk && !prev_blk) begin   // Frame starts with the clear
        wht_last <= wht_this;
        wht_this <= 1'b0;
      end
      if (wht) begin
        wht_this <= 1'b1;
        bx_prev  <= pix.x;
        by_prev  <= pix.y;
      end
      if (wht && !wht_last) armed <= 1'b0;
      else if (btn_fire) armed <= 1'b1;
      if (red) red_cnt <= red_cnt + 1'b1;
      else if (pix_valid) red_cnt <= '0;
      if (red && red_cnt[3:0] == 4'd0) begin
        ax_prev[idx] <= pix.x;
        ay_prev[idx] <= pix.y;
      end
    end
  end

  a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
    !in_game |-> !pix_valid)
    else begin
      $error("pixel written while no game is running");
      fail_count++;
    end

  a_idle_hold: assert property (@(posedge clk) disable iff (rst)
    !in_game && !go |=> !in_game)
    else begin
      $error("game started without go");
      fail_count++;
    end

  a_layer_order: assert property (@(posedge clk) disable iff (rst)
    pix_valid && !prev_valid |-> legal_next(last_col, pix.colour))
    else begin
      $error("MISMATCH %0t: layer colour %0d out of frame order", $time, pix.colour);
      fail_count++;
    end

  a_clr_origin: assert property (@(posedge clk) disable iff (rst)
    blk && !prev_blk |-> pix.x == 0 && pix.y == 0)
    else begin
      $error("MISMATCH %0t: clear starts at (%0d,%0d)", $time, pix.x, pix.y);
      fail_count++;
    end

  a_clr_step: assert property (@(posedge clk) disable iff (rst)
    blk && prev_blk |-> (prev_pix.x == invaders_pkg::SCREEN_W - 1) ?
      (pix.x == 0 && pix.y == prev_pix.y + 1) :
      (pix.x == prev_pix.x + 1 && pix.y == prev_pix.y))
    else begin
      $error("MISMATCH %0t: clear pixel (%0d,%0d) out of raster order", $time, pix.x, pix.y);
      fail_count++;
    end

  a_clr_run: assert property (@(posedge clk) disable iff (rst)
    prev_blk |-> blk == !(prev_pix.x == invaders_pkg::SCREEN_W - 1 &&
                          prev_pix.y == invaders_pkg::SCREEN_H - 1))
    else begin
      $error("MISMATCH %0t: clear run broken or too long", $time);
      fail_count++;
    end

  a_ply_first: assert property (@(posedge clk) disable iff (rst)
    grn && !prev_grn |-> pix.y == invaders_pkg::PLAYER_Y0 &&
      int'(pix.x) <= invaders_pkg::SCREEN_W - invaders_pkg::PLAYER_W &&
      (pix.x == px_cur ||
       (pix.x == px_cur + 1 && $past(btn_right, 2) && !$past(btn_left, 2)) ||
       (pix.x + 1 == px_cur && $past(btn_left, 2) && !$past(btn_right, 2))))
    else begin
      $error("MISMATCH %0t: player box at (%0d,%0d), was x %0d", $time, pix.x, pix.y, px_cur);
      fail_count++;
    end

  a_ply_box: assert property (@(posedge clk) disable iff (rst)
    grn && prev_grn |-> pix.x >= px_cur && pix.x <= px_cur + 3 &&
      pix.y >= invaders_pkg::PLAYER_Y0 && pix.y <= invaders_pkg::PLAYER_Y0 + 3)
    else begin
      $error("MISMATCH %0t: green pixel (%0d,%0d) outside the player box", $time, pix.x, pix.y);
      fail_count++;
    end

  a_aln_lane: assert property (@(posedge clk) disable iff (rst)
    red |-> int'(idx) < N_ALIENS && int'(pix.x) >= lane_lo &&
      int'(pix.x) <= lane_lo + invaders_pkg::LANE_W - 1 &&
      pix.y >= invaders_pkg::ALIEN_Y0)
    else begin
      $error("MISMATCH %0t: alien %0d pixel (%0d,%0d) off its lane", $time, idx, pix.x, pix.y);
      fail_count++;
    end

  a_aln_step: assert property (@(posedge clk) disable iff (rst)
    red && red_cnt[3:0] == 4'd0 |->
      (pix.x == ax_prev[idx] || pix.x == ax_prev[idx] + 1 || pix.x + 1 == ax_prev[idx]) &&
      (pix.y == ay_prev[idx] ||
       (pix.y == ay_prev[idx] + 1 && pix.x == ax_prev[idx] &&
        (int'(pix.x) == lane_lo ||
         int'(pix.x) == lane_lo + invaders_pkg::LANE_W - invaders_pkg::ALIEN_W))))
    else begin
      $error("MISMATCH %0t: alien %0d moved badly to (%0d,%0d)", $time, idx, pix.x, pix.y);
      fail_count++;
    end

  a_blt_launch: assert property (@(posedge clk) disable iff (rst)
    wht && !wht_last |-> armed && pix.x == px_prev + 2 &&
      pix.y == invaders_pkg::PLAYER_Y0 - 1)
    else begin
      $error("MISMATCH %0t: bullet appears at (%0d,%0d)", $time, pix.x, pix.y);
      fail_count++;
    end

  a_blt_climb: assert property (@(posedge clk) disable iff (rst)
    wht && wht_last |-> pix.x == bx_prev && pix.y + 1 == by_prev)
    else begin
      $error("MISMATCH %0t: bullet at (%0d,%0d) after row %0d", $time, pix.x, pix.y, by_prev);
      fail_count++;
    end

endmodule

bind invaders_top invaders_chk #(.N_ALIENS(N_ALIENS)) chk0 (
  .clk      (clk),
  .rst      (rst),
  .go       (go),
  .btn_left (btn_left),
  .btn_right(btn_right),
  .btn_fire (btn_fire),
  .in_game  (in_game),
  .pix_valid(pix_valid),
  .pix      (pix)
);

/* src/invaders_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Invaders game core: frame timing, control, sprite
// state and the plot engine that emits the pixels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module invaders_top #(
  parameter int FRAME_DIV  = 833333,
  parameter int PLAYER_DIV = 10,
  parameter int ALIEN_DIV  = 15,
  parameter int BULLET_DIV = 6,
  parameter int N_ALIENS   = 3      // At most 5 lanes fit on screen
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 go,
  input  logic                 btn_left,
  input  logic                 btn_right,
  input  logic                 btn_fire,
  output invaders_pkg::pixel_t pix,
  output logic                 pix_valid,
  output logic                 in_game
);

  logic                                    frame_tick;
  invaders_pkg::move_due_t                 due;
  logic                                    new_game;
  logic                                    update;
  logic                                    plot_start;
  invaders_pkg::layer_t                    plot_layer;
  logic                                    plot_done;
  invaders_pkg::sprite_pos_t               player_pos;
  invaders_pkg::sprite_pos_t [N_ALIENS-1:0] alien_pos;
  invaders_pkg::sprite_pos_t               bullet_pos;
  logic                                    bullet_flying;

  frame_timer #(
    .FRAME_DIV (FRAME_DIV),
    .PLAYER_DIV(PLAYER_DIV),
    .ALIEN_DIV (ALIEN_DIV),
    .BULLET_DIV(BULLET_DIV)
  ) u_timer (
    .clk       (clk),
    .rst       (rst),
    .in_game   (in_game),
    .frame_tick(frame_tick),
    .due       (due)
  );

  game_control u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .go           (go),
    .frame_tick   (frame_tick),
    .plot_done    (plot_done),
    .bullet_flying(bullet_flying),
    .in_game      (in_game),
    .new_game     (new_game),
    .update       (update),
    .plot_start   (plot_start),
    .plot_layer   (plot_layer)
  );

  player_ship u_ship (
    .clk(clk), .rst(rst), .new_game(new_game), .update(update),
    .step(due.player), .btn_left(btn_left), .btn_right(btn_right),
    .player_pos(player_pos)
  );

  alien_row #(.N_ALIENS(N_ALIENS)) u_aliens (
    .clk(clk), .rst(rst), .new_game(new_game), .update(update),
    .step(due.alien), .alien_pos(alien_pos)
  );

  player_bullet u_bullet (
    .clk(clk), .rst(rst), .new_game(new_game), .update(update),
    .step(due.bullet), .btn_fire(btn_fire), .player_pos(player_pos),
    .bullet_pos(bullet_pos), .bullet_flying(bullet_flying)
  );

  plot_engine #(.N_ALIENS(N_ALIENS)) u_plot (
    .clk       (clk),
    .rst       (rst),
    .plot_start(plot_start),
    .plot_layer(plot_layer),
    .player_pos(player_pos),
    .alien_pos (alien_pos),
    .bullet_pos(bullet_pos),
    .plot_done (plot_done),
    .pix       (pix),
    .pix_valid (pix_valid)
  );

endmodule

/* src/plot_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Turns plot requests into one pixel per clock: the
// clear raster, sprite boxes or the bullet pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module plot_engine #(
  parameter int N_ALIENS = 3
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    plot_start,
  input  invaders_pkg::layer_t                     plot_layer,
  input  invaders_pkg::sprite_pos_t                player_pos,
  input  invaders_pkg::sprite_pos_t [N_ALIENS-1:0] alien_pos,
  input  invaders_pkg::sprite_pos_t                bullet_pos,
  output logic                                    plot_done,
  output invaders_pkg::pixel_t                     pix,
  output logic                                    pix_valid
);

  localparam int IDX_W = (N_ALIENS > 1) ? $clog2(N_ALIENS) : 1;

  logic                      busy;
  invaders_pkg::layer_t      layer;
  invaders_pkg::coord_x_t    cx;      // Column offset inside the walk
  invaders_pkg::coord_y_t    cy;
  logic [IDX_W-1:0]          idx;     // Alien being drawn
  invaders_pkg::sprite_pos_t base;
  invaders_pkg::coord_x_t    x_last;
  invaders_pkg::coord_y_t    y_last;
  invaders_pkg::colour_t     colour;
  logic                      box_end;
  logic                      last;

  // Origin, extent and colour of the current walk
  always_comb begin
    base   = '0;
    x_last = '0;
    y_last = '0;
    colour = invaders_pkg::COL_BLACK;
    case (layer)
      invaders_pkg::LAYER_CLEAR: begin
        x_last = invaders_pkg::coord_x_t'(invaders_pkg::SCREEN_W - 1);
        y_last = invaders_pkg::coord_y_t'(invaders_pkg::SCREEN_H - 1);
      end
      invaders_pkg::LAYER_PLAYER: begin
        base   = player_pos;
        x_last = invaders_pkg::coord_x_t'(invaders_pkg::PLAYER_W - 1);
        y_last = invaders_pkg::coord_y_t'(invaders_pkg::PLAYER_H - 1);
        colour = invaders_pkg::COL_PLAYER;
      end
      invaders_pkg::LAYER_ALIENS: begin
        base   = alien_pos[idx];
        x_last = invaders_pkg::coord_x_t'(invaders_pkg::ALIEN_W - 1);
        y_last = invaders_pkg::coord_y_t'(invaders_pkg::ALIEN_H - 1);
        colour = invaders_pkg::COL_ALIEN;
      end
      default: begin
        base   = bullet_pos;       // Single pixel, extent stays zero
        colour = invaders_pkg::COL_BULLET;
      end
    endcase
  end

  assign box_end = (cx == x_last) && (cy == y_last);
  assign last    = box_end &&
                   ((layer != invaders_pkg::LAYER_ALIENS) || (idx == IDX_W'(N_ALIENS - 1)));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy  <= 1'b0;
      layer <= invaders_pkg::LAYER_CLEAR;
      cx    <= '0;
      cy    <= '0;
      idx   <= '0;
    end else if (plot_start) begin
      busy  <= 1'b1;
      layer <= plot_layer;
      cx    <= '0;
      cy    <= '0;
      idx   <= '0;
    end else if (busy) begin
      if (last) begin
        busy <= 1'b0;
      end else if (box_end) begin
        cx  <= '0;                  // Next alien box
        cy  <= '0;
        idx <= idx + 1'b1;
      end else if (cx == x_last) begin
        cx <= '0;
        cy <= cy + 1'b1;
      end else begin
        cx <= cx + 1'b1;
      end
    end
  end

  assign pix.x      = base.x + cx;
  assign pix.y      = base.y + cy;
  assign pix.colour = colour;
  assign pix_valid  = busy;
  assign plot_done  = busy && last;

endmodule

/* src/player_bullet.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single player bullet: launch from the ship, climb
// one row per step, retire at the top row
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module player_bullet (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      new_game,
  input  logic                      update,
  input  logic                      step,
  input  logic                      btn_fire,
  input  invaders_pkg::sprite_pos_t player_pos,
  output invaders_pkg::sprite_pos_t bullet_pos,
  output logic                      bullet_flying
);

  // Launch point is just above the middle of the ship
  localparam invaders_pkg::coord_y_t Y_LAUNCH = invaders_pkg::PLAYER_Y0 - 7'd1;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bullet_flying <= 1'b0;
      bullet_pos.x  <= invaders_pkg::PLAYER_X0;
      bullet_pos.y  <= Y_LAUNCH;
    end else if (new_game) begin
      bullet_flying <= 1'b0;
      bullet_pos.x  <= invaders_pkg::PLAYER_X0;
      bullet_pos.y  <= Y_LAUNCH;
    end else if (update) begin
      if (bullet_flying) begin
        if (bullet_pos.y == '0) begin
          bullet_flying <= 1'b0;           // Reached the top
        end else if (step) begin
          bullet_pos.y <= bullet_pos.y - 1'b1;
        end
      end else if (btn_fire) begin
        bullet_flying <= 1'b1;
        bullet_pos.x  <= player_pos.x + 8'd2;
        bullet_pos.y  <= Y_LAUNCH;
      end
    end
  end

endmodule

/* src/alien_row.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Alien positions, each one marching inside its own
// lane and stepping down a row at every turn
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module alien_row #(
  parameter int N_ALIENS = 3
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    new_game,
  input  logic                                    update,
  input  logic                                    step,
  output invaders_pkg::sprite_pos_t [N_ALIENS-1:0] alien_pos
);

  for (genvar i = 0; i < N_ALIENS; i++) begin : g_alien
    // Lane bounds for the box's left column
    localparam invaders_pkg::coord_x_t X_LO =
      invaders_pkg::coord_x_t'(int'(invaders_pkg::ALIEN_X0) + i * invaders_pkg::LANE_W);
    localparam invaders_pkg::coord_x_t X_HI =
      invaders_pkg::coord_x_t'(int'(X_LO) + invaders_pkg::LANE_W - invaders_pkg::ALIEN_W);

    invaders_pkg::coord_x_t x_q;
    invaders_pkg::coord_y_t y_q;
    logic                   dir_left;   // Low while marching right
    logic                   at_edge;

    assign at_edge = dir_left ? (x_q == X_LO) : (x_q == X_HI);

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        x_q      <= X_LO;
        y_q      <= invaders_pkg::ALIEN_Y0;
        dir_left <= 1'b0;
      end else if (new_game) begin
        x_q      <= X_LO;
        y_q      <= invaders_pkg::ALIEN_Y0;
        dir_left <= 1'b0;
      end else if (update && step) begin
        if (at_edge) begin
          dir_left <= !dir_left;   // Turn takes the whole step
          if (y_q < invaders_pkg::ALIEN_Y_MAX) begin
            y_q <= y_q + 1'b1;
          end
        end else if (dir_left) begin
          x_q <= x_q - 1'b1;
        end else begin
          x_q <= x_q + 1'b1;
        end
      end
    end

    assign alien_pos[i].x = x_q;
    assign alien_pos[i].y = y_q;
  end

endmodule

/* src/player_ship.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Player position, moved by the buttons at stepped
// updates and kept inside the screen
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module player_ship (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     new_game,
  input  logic                     update,
  input  logic                     step,
  input  logic                     btn_left,
  input  logic                     btn_right,
  output invaders_pkg::sprite_pos_t player_pos
);

  localparam int X_MAX = invaders_pkg::SCREEN_W - invaders_pkg::PLAYER_W;

  invaders_pkg::coord_x_t x_q;
  logic                   go_left;
  logic                   go_right;

  // Both buttons held means no move
  assign go_left  = btn_left && !btn_right && (x_q != '0);
  assign go_right = btn_right && !btn_left && (int'(x_q) < X_MAX);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      x_q <= invaders_pkg::PLAYER_X0;
    end else if (new_game) begin
      x_q <= invaders_pkg::PLAYER_X0;
    end else if (update && step) begin
      if (go_left) begin
        x_q <= x_q - 1'b1;
      end else if (go_right) begin
        x_q <= x_q + 1'b1;
      end
    end
  end

  assign player_pos.x = x_q;
  assign player_pos.y = invaders_pkg::PLAYER_Y0;   // Ship never leaves its row

endmodule

/* src/game_control.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame sequencing FSM: clear, update, then one plot
// request per sprite layer, then wait for the tick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module game_control (
  input  logic                clk,
  input  logic                rst,
  input  logic                go,
  input  logic                frame_tick,
  input  logic                plot_done,
  input  logic                bullet_flying,
  output logic                in_game,
  output logic                new_game,
  output logic                update,
  output logic                plot_start,
  output invaders_pkg::layer_t plot_layer
);

  typedef enum logic [2:0] {
    IDLE,
    START,
    CLEAR,
    UPDATE,
    PLOT_PLAYER,
    PLOT_ALIENS,
    PLOT_BULLET,
    WAIT_FRAME
  } state_t;

  state_t state;
  state_t state_nx;

  always_comb begin
    state_nx = state;
    case (state)
      IDLE:        if (go) state_nx = START;
      START:       state_nx = CLEAR;
      CLEAR:       if (plot_done) state_nx = UPDATE;
      UPDATE:      state_nx = PLOT_PLAYER;
      PLOT_PLAYER: if (plot_done) state_nx = PLOT_ALIENS;
      PLOT_ALIENS: begin
        if (plot_done) state_nx = bullet_flying ? PLOT_BULLET : WAIT_FRAME;
      end
      PLOT_BULLET: if (plot_done) state_nx = WAIT_FRAME;
      WAIT_FRAME:  if (frame_tick) state_nx = CLEAR;  // Ticks elsewhere are dropped
      default:     state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nx;
    end
  end

  // Request goes out in the first cycle of each drawing state
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      plot_start <= 1'b0;
      plot_layer <= invaders_pkg::LAYER_CLEAR;
    end else begin
      plot_start <= 1'b0;
      if (state_nx != state) begin
        case (state_nx)
          CLEAR: begin
            plot_start <= 1'b1;
            plot_layer <= invaders_pkg::LAYER_CLEAR;
          end
          PLOT_PLAYER: begin
            plot_start <= 1'b1;
            plot_layer <= invaders_pkg::LAYER_PLAYER;
          end
          PLOT_ALIENS: begin
            plot_start <= 1'b1;
            plot_layer <= invaders_pkg::LAYER_ALIENS;
          end
          PLOT_BULLET: begin
            plot_start <= 1'b1;
            plot_layer <= invaders_pkg::LAYER_BULLET;
          end
          default: ;
        endcase
      end
    end
  end

  assign in_game  = (state != IDLE);
  assign new_game = (state == START);   // Single cycle, START never repeats
  assign update   = (state == UPDATE);

endmodule

/* src/frame_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame tick strobe and per-object movement flags,
// idle and cleared while no game is running
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module frame_timer #(
  parameter int FRAME_DIV  = 833333,
  parameter int PLAYER_DIV = 10,
  parameter int ALIEN_DIV  = 15,
  parameter int BULLET_DIV = 6
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_game,
  output logic                   frame_tick,
  output invaders_pkg::move_due_t due
);

  localparam int FW = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;

  logic [FW-1:0] clk_cnt;
  logic          frame_wrap;
  logic [2:0]    due_vec;   // Player, alien, bullet from msb down

  assign frame_wrap = in_game && (clk_cnt == FW'(FRAME_DIV - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_cnt    <= '0;
      frame_tick <= 1'b0;
    end else if (!in_game) begin
      clk_cnt    <= '0;
      frame_tick <= 1'b0;
    end else begin
      clk_cnt    <= frame_wrap ? '0 : clk_cnt + 1'b1;
      frame_tick <= frame_wrap;
    end
  end

  // One frame counter per object, flag held for a whole frame
  for (genvar i = 0; i < 3; i++) begin : g_rate
    localparam int DIV = (i == 2) ? PLAYER_DIV : (i == 1) ? ALIEN_DIV : BULLET_DIV;
    localparam int RW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic [RW-1:0] frm_cnt;
    logic          flag;

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        frm_cnt <= '0;
        flag    <= 1'b0;
      end else if (!in_game) begin
        frm_cnt <= '0;
        flag    <= 1'b0;
      end else if (frame_wrap) begin
        flag    <= (frm_cnt == RW'(DIV - 1));
        frm_cnt <= (frm_cnt == RW'(DIV - 1)) ? '0 : frm_cnt + 1'b1;
      end
    end

    assign due_vec[i] = flag;
  end

  assign due = invaders_pkg::move_due_t'(due_vec);

endmodule

/* src/invaders_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Screen geometry, colours and shared types for the
// invaders core, used by scoped name in every module
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package invaders_pkg;

  typedef logic [7:0] coord_x_t;  // Screen column
  typedef logic [6:0] coord_y_t;  // Screen row
  typedef logic [2:0] colour_t;   // One bit per RGB channel

  // One pixel write on the output stream
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    colour_t  colour;
  } pixel_t;

  // Top-left corner of a sprite
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
  } sprite_pos_t;

  // Objects allowed to move at the coming update
  typedef struct packed {
    logic player;
    logic alien;
    logic bullet;
  } move_due_t;

  typedef enum logic [1:0] {
    LAYER_CLEAR,
    LAYER_PLAYER,
    LAYER_ALIENS,
    LAYER_BULLET
  } layer_t;

  localparam int SCREEN_W = 160;
  localparam int SCREEN_H = 120;
  localparam int PLAYER_W = 4;
  localparam int PLAYER_H = 4;
  localparam int ALIEN_W  = 4;
  localparam int ALIEN_H  = 4;
  localparam int LANE_W   = 20;   // Each alien marches in its own lane

  localparam coord_x_t PLAYER_X0   = 8'd68;
  localparam coord_y_t PLAYER_Y0   = 7'd111;
  localparam coord_x_t ALIEN_X0    = 8'd50;  // Left edge of lane 0
  localparam coord_y_t ALIEN_Y0    = 7'd15;
  localparam coord_y_t ALIEN_Y_MAX = 7'd100; // Floor row for the descent

  localparam colour_t COL_BLACK  = 3'd0;
  localparam colour_t COL_PLAYER = 3'd2;   // Green
  localparam colour_t COL_ALIEN  = 3'd4;   // Red
  localparam colour_t COL_BULLET = 3'd7;   // White

endpackage
